// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = keypad_tb
FILE_LIST = files.f
PASS_MSG  = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# Exit status comes from the search for the pass message
test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: dv/keypad_golden.txt
# row(dec) col_mask(hex) hold(cycles) left_seg(hex) right_seg(hex), segments g..a active low
# Mask 0 presses nothing, several mask bits press several keys in one row
0 0 10 40 40
0 1 80 40 79
0 2 80 79 24
0 4 80 24 30
0 8 80 30 08
1 1 80 08 19
1 2 80 19 12
1 4 80 12 02
1 8 80 02 03
2 1 80 03 78
2 2 80 78 00
2 4 80 00 10
2 8 80 10 46
3 1 80 46 06
3 2 80 06 40
3 4 80 40 0e
3 8 80 0e 21
1 2 4 0e 21
2 2 400 21 00
2 2 80 00 00
0 4 80 00 30
0 4 80 30 30
0 3 80 30 30
3 c 80 30 30

// File: dv/keypad_props.sv
// Concurrent assertions on the keypad display top level and its debouncer
// Attached to keypad_display_top by the bind at the end of this file
`timescale 1ns/1ps
`default_nettype none

module keypad_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic [keypad_pkg::ROWS-1:0]  keypad_rows,
    input logic                         select0,
    input logic                         select1,
    input logic                         key_valid,
    input logic                         scan_hold,
    input keypad_pkg::debounce_state_e  db_state     // Debouncer FSM state
);

    // ========================================
    // Debouncer
    // ========================================
    valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |=> !key_valid)
        else $error("key_valid high on two cycles in a row");

    hold_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (db_state == keypad_pkg::IDLE) |-> !scan_hold)
        else $error("scan_hold high while debouncer idle");

    // ========================================
    // Pins
    // ========================================
    // From the second cycle out of reset exactly one digit is lit
    select_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (select0 ^ select1))
        else $error("Digit selects not exactly one high");

    row_onecold: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~keypad_rows) == 1)
        else $error("keypad_rows does not have exactly one low bit");

endmodule

bind keypad_display_top keypad_props props0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .keypad_rows (keypad_rows),
    .select0     (select0),
    .select1     (select1),
    .key_valid   (key_valid),
    .scan_hold   (scan_hold),
    .db_state    (debouncer_inst.state)
);

`default_nettype wire

// File: dv/keypad_tb.sv
// Testbench for the keypad display top level with the press list read from a golden file
// Models the keypad matrix, runs each press and checks both displayed digits
`timescale 1ns/1ps
`default_nettype none

module keypad_tb;

    // ========================================
    // DUT signals and stimulus state
    // ========================================
    logic                         clk;
    logic                         rst_n;
    logic [keypad_pkg::COLS-1:0]  keypad_cols;
    logic [keypad_pkg::ROWS-1:0]  keypad_rows;
    logic [keypad_pkg::SEG_W-1:0] seg;
    logic                         select0;
    logic                         select1;

    logic [keypad_pkg::ROW_IDX_W-1:0] press_row;    // Row of the pressed key set
    logic [keypad_pkg::COLS-1:0]      press_cols;   // Pressed columns in that row

    // One entry per golden line
    logic [keypad_pkg::ROW_IDX_W-1:0] row_q[$];
    logic [keypad_pkg::COLS-1:0]      mask_q[$];
    int                               hold_q[$];
    logic [keypad_pkg::SEG_W-1:0]     left_q[$];
    logic [keypad_pkg::SEG_W-1:0]     right_q[$];

    logic [31:0] lfsr_state  = 32'h2de1_82ff;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;                   // Zero until the golden file is read
    int          checks      = 0;
    int          errors      = 0;
    logic        golden_ok;

    keypad_display_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .keypad_cols (keypad_cols),
        .keypad_rows (keypad_rows),
        .seg         (seg),
        .select0     (select0),
        .select1     (select1)
    );

    // Column reads low when its key is down and its row is driven low
    always_comb begin
        keypad_cols = '1;                           // Board pull-ups
        for (int c = 0; c < keypad_pkg::COLS; c++) begin
            if (press_cols[c] && !keypad_rows[press_row]) keypad_cols[c] = 1'b0;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                     // 20 ns period
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) lfsr_next = (s >> 1) ^ 32'h8020_0003;
        else      lfsr_next = s >> 1;
    endfunction

    task automatic random_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic load_golden(output logic ok);
        int                               fd;
        int                               n;
        string                            line;
        logic [keypad_pkg::ROW_IDX_W-1:0] r;
        logic [keypad_pkg::COLS-1:0]      m;
        int                               h;
        logic [keypad_pkg::SEG_W-1:0]     l;
        logic [keypad_pkg::SEG_W-1:0]     rt;
        fd = $fopen("dv/keypad_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open golden file dv/keypad_golden.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin   // Skip blanks and comments
                    n = $sscanf(line, "%d %h %d %h %h", r, m, h, l, rt);
                    if (n == 5) begin
                        row_q.push_back(r);
                        mask_q.push_back(m);
                        hold_q.push_back(h);
                        left_q.push_back(l);
                        right_q.push_back(rt);
                    end else begin
                        errors++;
                        $display("Malformed golden line ignored: %s", line);
                    end
                end
            end
            $fclose(fd);
            ok = (row_q.size() > 0);
            if (!ok) $display("Golden file holds no press steps");
        end
    endtask

    // Worst case per step is longest gap, two select periods and the press latency
    function automatic int timeout_cycles();
        int hold_sum;
        int per_step;
        hold_sum = 0;
        foreach (hold_q[i]) hold_sum += hold_q[i];
        per_step = (keypad_pkg::RELEASE_COUNT + 4 + 15) + 2 * keypad_pkg::MUX_DIV
                 + keypad_pkg::ROWS * keypad_pkg::SCAN_DIV + 2 + keypad_pkg::DEBOUNCE_COUNT + 2;
        timeout_cycles = hold_sum + hold_q.size() * per_step + 100;   // Margin for reset
    endfunction

    task automatic check_digit(input logic is_right, input logic [keypad_pkg::SEG_W-1:0] exp,
                               input int step);
        string side;
        if (is_right) begin
            side = "right";
            while (!select1) @(negedge clk);
        end else begin
            side = "left";
            while (!select0) @(negedge clk);
        end
        checks++;
        if (seg !== exp) begin
            errors++;
            $display("ERR %0t: step %0d %s digit seg=%h expected %h", $time, step,
                     side, seg, exp);
        end
    endtask

    task automatic run_step(input int i);
        int extra;
        press_row  = row_q[i];
        press_cols = mask_q[i];
        repeat (hold_q[i]) @(negedge clk);
        press_cols = '0;                            // All keys up
        random_bits(4, extra);                      // 0..15 extra idle cycles
        repeat (keypad_pkg::RELEASE_COUNT + 4 + extra) @(negedge clk);
        check_digit(1'b0, left_q[i], i);
        check_digit(1'b1, right_q[i], i);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        rst_n      = 1'b0;
        press_row  = '0;
        press_cols = '0;
        load_golden(golden_ok);
        if (!golden_ok) begin
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = timeout_cycles();
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;                           // Released on a falling edge
            for (int i = 0; i < row_q.size(); i++) run_step(i);
            $display("Steps: %0d, checks: %0d, errors: %0d", row_q.size(), checks, errors);
            if (errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
verilog/keypad_pkg.sv
verilog/keypad_scanner.sv
verilog/key_decoder.sv
verilog/key_debouncer.sv
verilog/display_driver.sv
verilog/keypad_display_top.sv
dv/keypad_props.sv
dv/keypad_tb.sv

// File: verilog/display_driver.sv
// Two-digit display history with a time-multiplexed seven-segment output
// Each key_valid strobe shifts right into left and loads the new key on the right
`timescale 1ns/1ps
`default_nettype none

module display_driver (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         key_valid,
    input  logic [keypad_pkg::KEY_W-1:0] key_out,
    output logic [keypad_pkg::SEG_W-1:0] seg,      // g..a, active low
    output logic                         select0,  // Left digit enable
    output logic                         select1   // Right digit enable
);

    logic [keypad_pkg::KEY_W-1:0]     digit_left;
    logic [keypad_pkg::KEY_W-1:0]     digit_right;
    logic [keypad_pkg::KEY_W-1:0]     digit_shown;  // Digit under the active select
    logic [keypad_pkg::MUX_CNT_W-1:0] mux_cnt;

    // ========================================
    // Digit history
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_left  <= '0;
            digit_right <= '0;
        end else if (key_valid) begin
            digit_left  <= digit_right;     // Older key moves left
            digit_right <= key_out;         // Newest key on the right
        end
    end

    // ========================================
    // Digit select multiplexing
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mux_cnt <= '0;
            select0 <= 1'b0;                // Both digits dark in reset
            select1 <= 1'b0;
        end else if (!select0 && !select1) begin
            select0 <= 1'b1;                // First cycle out of reset, start on the left
            mux_cnt <= '0;
        end else if (mux_cnt == keypad_pkg::MUX_LAST) begin
            mux_cnt <= '0;
            select0 <= ~select0;
            select1 <= ~select1;
        end else begin
            mux_cnt <= mux_cnt + 1'b1;
        end
    end

    assign digit_shown = select1 ? digit_right : digit_left;

    // ========================================
    // Hex to segments, active low
    // ========================================
    always_comb begin
        case (digit_shown)          //   gfedcba
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b0000011;  // Lower case b
            4'hC:    seg = 7'b1000110;
            4'hD:    seg = 7'b0100001;  // Lower case d
            4'hE:    seg = 7'b0000110;
            default: seg = 7'b0001110;  // F
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/key_debouncer.sv
// Qualifies a decoded key over DEBOUNCE_COUNT stable samples and strobes it once
// Holds the scanner on the key's row from first sight until full release
`timescale 1ns/1ps
`default_nettype none

module key_debouncer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [keypad_pkg::KEY_W-1:0] key_code,
    input  logic                         key_present,
    output logic                         key_valid,  // One-cycle strobe per press
    output logic [keypad_pkg::KEY_W-1:0] key_out,    // Valid with key_valid
    output logic                         scan_hold   // High in every state but IDLE
);

    keypad_pkg::debounce_state_e     state, state_next;
    logic [keypad_pkg::DB_CNT_W-1:0] cnt, cnt_next;  // Shared by QUALIFY and RELEASE
    logic [keypad_pkg::KEY_W-1:0]    cand;           // Code seen on entry to QUALIFY
    logic                            accept;         // Qualification done this cycle

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_next = state;
        cnt_next   = cnt;
        accept     = 1'b0;
        case (state)
            keypad_pkg::IDLE: begin
                if (key_present) begin
                    state_next = keypad_pkg::QUALIFY;
                    cnt_next   = keypad_pkg::CNT_ONE;          // This sample counts
                end
            end
            keypad_pkg::QUALIFY: begin
                if (!key_present || key_code != cand) begin
                    state_next = keypad_pkg::IDLE;             // Bounce or different key
                end else if (cnt == keypad_pkg::DEBOUNCE_LAST) begin
                    state_next = keypad_pkg::HELD;
                    accept     = 1'b1;
                end else begin
                    cnt_next = cnt + 1'b1;
                end
            end
            keypad_pkg::HELD: begin
                if (!key_present) begin
                    state_next = keypad_pkg::RELEASE;
                    cnt_next   = keypad_pkg::CNT_ONE;
                end
            end
            keypad_pkg::RELEASE: begin
                if (key_present) begin
                    state_next = keypad_pkg::HELD;             // Release bounce, no new pulse
                end else if (cnt == keypad_pkg::RELEASE_LAST) begin
                    state_next = keypad_pkg::IDLE;             // Rearmed
                end else begin
                    cnt_next = cnt + 1'b1;
                end
            end
            default: state_next = keypad_pkg::IDLE;
        endcase
    end

    // ========================================
    // Registers
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= keypad_pkg::IDLE;
            cnt       <= '0;
            key_valid <= 1'b0;
            scan_hold <= 1'b0;
        end else begin
            state     <= state_next;
            cnt       <= cnt_next;
            key_valid <= accept;
            scan_hold <= (state_next != keypad_pkg::IDLE);     // Rises one cycle after presence
        end
    end

    always_ff @(posedge clk) begin
        if (state == keypad_pkg::IDLE) cand <= key_code;      // Candidate for comparison
        if (accept) key_out <= cand;
    end

endmodule

`default_nettype wire

// File: verilog/key_decoder.sv
// Maps the strobed row and synchronized columns to a hex key code
// Presence is raised only for a single low column on a single low row
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  logic [keypad_pkg::ROWS-1:0]  row_strobe,  // One-cold
    input  logic [keypad_pkg::COLS-1:0]  col_sync,    // Active low
    output logic [keypad_pkg::KEY_W-1:0] key_code,
    output logic                         key_present
);

    logic [keypad_pkg::ROW_IDX_W-1:0] row_idx;
    logic [keypad_pkg::COL_IDX_W-1:0] col_idx;
    logic                             row_ok;        // Exactly one row low
    logic                             col_ok;        // Exactly one column low

    // ========================================
    // Position of the low bits
    // ========================================
    always_comb begin
        row_idx = '0;
        col_idx = '0;
        for (int r = 0; r < keypad_pkg::ROWS; r++) begin
            if (!row_strobe[r]) row_idx = r[keypad_pkg::ROW_IDX_W-1:0];
        end
        for (int c = 0; c < keypad_pkg::COLS; c++) begin
            if (!col_sync[c]) col_idx = c[keypad_pkg::COL_IDX_W-1:0];
        end
    end

    assign row_ok      = ($countones(~row_strobe) == 1);
    assign col_ok      = ($countones(~col_sync) == 1);   // Rejects two or more keys
    assign key_present = row_ok && col_ok;

    // ========================================
    // Keypad map, {row, col} to hex
    // ========================================
    always_comb begin
        case ({row_idx, col_idx})
            4'd0:    key_code = 4'h1;
            4'd1:    key_code = 4'h2;
            4'd2:    key_code = 4'h3;
            4'd3:    key_code = 4'hA;
            4'd4:    key_code = 4'h4;
            4'd5:    key_code = 4'h5;
            4'd6:    key_code = 4'h6;
            4'd7:    key_code = 4'hB;
            4'd8:    key_code = 4'h7;
            4'd9:    key_code = 4'h8;
            4'd10:   key_code = 4'h9;
            4'd11:   key_code = 4'hC;
            4'd12:   key_code = 4'hE;   // Star position on a phone-style pad
            4'd13:   key_code = 4'h0;
            4'd14:   key_code = 4'hF;   // Hash position
            default: key_code = 4'hD;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/keypad_display_top.sv
// Keypad to seven-segment top level, scanner through display driver
// Board pins only; the clock arrives on a port
`timescale 1ns/1ps
`default_nettype none

module keypad_display_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [keypad_pkg::COLS-1:0] keypad_cols,  // Active low, pulled up on board
    output logic [keypad_pkg::ROWS-1:0] keypad_rows,  // One-cold row drive
    output logic [keypad_pkg::SEG_W-1:0] seg,
    output logic                        select0,
    output logic                        select1
);

    // ========================================
    // Internal nets
    // ========================================
    logic [keypad_pkg::ROWS-1:0]  row_strobe;    // Scanner to decoder
    logic [keypad_pkg::COLS-1:0]  col_sync;
    logic [keypad_pkg::KEY_W-1:0] key_code;      // Decoder to debouncer
    logic                         key_present;
    logic                         key_valid;     // Debouncer to display
    logic [keypad_pkg::KEY_W-1:0] key_out;
    logic                         scan_hold;     // Debouncer back to scanner

    keypad_scanner scanner_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .scan_hold   (scan_hold),
        .keypad_cols (keypad_cols),
        .keypad_rows (keypad_rows),
        .row_strobe  (row_strobe),
        .col_sync    (col_sync)
    );

    key_decoder decoder_inst (
        .row_strobe  (row_strobe),
        .col_sync    (col_sync),
        .key_code    (key_code),
        .key_present (key_present)
    );

    key_debouncer debouncer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_code    (key_code),
        .key_present (key_present),
        .key_valid   (key_valid),
        .key_out     (key_out),
        .scan_hold   (scan_hold)
    );

    display_driver display_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_valid   (key_valid),
        .key_out     (key_out),
        .seg         (seg),
        .select0     (select0),
        .select1     (select1)
    );

endmodule

`default_nettype wire

// File: verilog/keypad_pkg.sv
// Shared sizes, timing constants and debouncer states for the keypad display design
// Modules refer to these by scoped name, keypad_pkg::NAME
`default_nettype none

package keypad_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int KEY_W     = 4;                      // Hex key code and display digit
    localparam int ROWS      = 4;
    localparam int COLS      = 4;
    localparam int SEG_W     = 7;                      // g..a, active low
    localparam int ROW_IDX_W = $clog2(ROWS);
    localparam int COL_IDX_W = $clog2(COLS);

    // ========================================
    // Timing, in clock cycles
    // ========================================
    localparam int SCAN_DIV       = 4;                 // Dwell per row while scanning
    localparam int DEBOUNCE_COUNT = 8;                 // Stable samples before accept
    localparam int RELEASE_COUNT  = 8;                 // Absent samples before rearm
    localparam int MUX_DIV        = 16;                // Dwell per digit select

    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);
    localparam int MUX_CNT_W  = $clog2(MUX_DIV);
    // One extra bit so either limit fits with room to spare
    localparam int DB_CNT_W   = $clog2((DEBOUNCE_COUNT > RELEASE_COUNT) ?
                                       DEBOUNCE_COUNT : RELEASE_COUNT) + 1;

    localparam logic [SCAN_CNT_W-1:0] SCAN_LAST     = SCAN_CNT_W'(SCAN_DIV - 1);
    localparam logic [MUX_CNT_W-1:0]  MUX_LAST      = MUX_CNT_W'(MUX_DIV - 1);
    localparam logic [DB_CNT_W-1:0]   DEBOUNCE_LAST = DB_CNT_W'(DEBOUNCE_COUNT - 1);
    localparam logic [DB_CNT_W-1:0]   RELEASE_LAST  = DB_CNT_W'(RELEASE_COUNT - 1);
    localparam logic [DB_CNT_W-1:0]   CNT_ONE       = DB_CNT_W'(1);

    // Row 0 strobed first, one-cold
    localparam logic [ROWS-1:0] ROW_FIRST = {{(ROWS - 1){1'b1}}, 1'b0};

    // Debouncer qualification FSM
    typedef enum logic [1:0] {
        IDLE,                                          // Waiting for any key
        QUALIFY,                                       // Counting stable samples
        HELD,                                          // Accepted, waiting for release
        RELEASE                                        // Counting absent samples
    } debounce_state_e;

endpackage

`default_nettype wire

// File: verilog/keypad_scanner.sv
// Row strobe generator and column synchronizer for a 4x4 active-low keypad
// Scan pauses while scan_hold is high so the pressed key's row stays driven
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        scan_hold,    // From debouncer, freeze on current row
    input  logic [keypad_pkg::COLS-1:0] keypad_cols,  // Raw pins, active low
    output logic [keypad_pkg::ROWS-1:0] keypad_rows,  // Driven pins, one-cold
    output logic [keypad_pkg::ROWS-1:0] row_strobe,   // Row aligned with col_sync
    output logic [keypad_pkg::COLS-1:0] col_sync      // Columns after two flops
);

    // ========================================
    // Row rotation
    // ========================================
    logic [keypad_pkg::SCAN_CNT_W-1:0] div_cnt;      // Dwell counter for the current row
    logic [keypad_pkg::ROWS-1:0]       row_reg;      // One-cold, drives the pins
    logic [keypad_pkg::ROWS-1:0]       row_d1;       // First delay stage of row copy
    logic [keypad_pkg::COLS-1:0]       col_meta;     // First synchronizer stage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            row_reg <= keypad_pkg::ROW_FIRST;         // Row 0 after reset
        end else if (scan_hold) begin
            // Stay on the row under qualification
            // and restart the dwell so release gives a full window
            div_cnt <= '0;
        end else if (div_cnt == keypad_pkg::SCAN_LAST) begin
            div_cnt <= '0;
            row_reg <= {row_reg[keypad_pkg::ROWS-2:0], row_reg[keypad_pkg::ROWS-1]};
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign keypad_rows = row_reg;

    // ========================================
    // Column sync and row alignment
    // ========================================
    // Columns take two flops to settle, so the row copy takes two as well.
    // The decoder then sees each column sample next to the row that made it.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_meta   <= '1;                        // Idle level, no key
            col_sync   <= '1;
            row_d1     <= keypad_pkg::ROW_FIRST;
            row_strobe <= keypad_pkg::ROW_FIRST;
        end else begin
            col_meta   <= keypad_cols;               // May go metastable
            col_sync   <= col_meta;                  // Safe to use from here
            row_d1     <= row_reg;
            row_strobe <= row_d1;
        end
    end

endmodule

`default_nettype wire
